//--- include/sdp_rdma_cfg.svh
`ifndef SDP_RDMA_CFG_SVH
`define SDP_RDMA_CFG_SVH

// ==========================================================================
// widths
// ==========================================================================
`define SDP_RDMA_ADDR_W       32    // memory byte address
`define SDP_RDMA_DATA_W       64    // one read return beat
`define SDP_RDMA_CNT_W        13    // words per operation
`define SDP_RDMA_CSB_ADDR_W   8     // register word address

`define SDP_RDMA_RET_DEPTH    4     // also the in-flight limit per engine
`define SDP_RDMA_REQ_DEPTH    2

// ==========================================================================
// register map, word offsets
// ==========================================================================
`define SDP_RDMA_REG_OP_EN      8'h00
`define SDP_RDMA_REG_MODE       8'h01   // bit0 flying, bit1 bias disable
`define SDP_RDMA_REG_SRC_BASE   8'h02
`define SDP_RDMA_REG_SRC_STRIDE 8'h03
`define SDP_RDMA_REG_SRC_COUNT  8'h04
`define SDP_RDMA_REG_BS_BASE    8'h05
`define SDP_RDMA_REG_BS_STRIDE  8'h06
`define SDP_RDMA_REG_BS_COUNT   8'h07

`endif

//--- src/sdp_rdma_reg_pkg.sv
`include "sdp_rdma_cfg.svh"

package sdp_rdma_reg_pkg;

  // ==========================================================================
  // control request / response channel
  // ==========================================================================
  typedef struct packed {
    logic                            write;  // 1 = write, 0 = read
    logic [`SDP_RDMA_CSB_ADDR_W-1:0] addr;   // word offset
    logic [31:0]                     wdata;
  } csb_req_t;

  typedef struct packed {
    logic        wr_ack;  // set on write responses only
    logic [31:0] rdata;
  } csb_resp_t;

  // ==========================================================================
  // per-engine settings
  // ==========================================================================
  typedef struct packed {
    logic [`SDP_RDMA_ADDR_W-1:0] base;
    logic [`SDP_RDMA_ADDR_W-1:0] stride;  // added once per request
    logic [`SDP_RDMA_CNT_W-1:0]  count;   // number of words to fetch
  } rdma_cfg_t;

endpackage

//--- src/sdp_rdma_dma_pkg.sv
`include "sdp_rdma_cfg.svh"

package sdp_rdma_dma_pkg;

  // memory read request, address only
  typedef struct packed {
    logic [`SDP_RDMA_ADDR_W-1:0] addr;
  } dma_rd_req_t;

  // in-order read return
  typedef struct packed {
    logic [`SDP_RDMA_DATA_W-1:0] data;
  } dma_rd_rsp_t;

  // word toward the datapath
  typedef struct packed {
    logic [`SDP_RDMA_DATA_W-1:0] data;
    logic                        last;  // final word of the operation
  } dp_data_t;

endpackage

//--- src/sdp_rdma_fifo.sv
`timescale 1ns/10ps

module sdp_rdma_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 2
) (
  input  logic     nvdla_core_clk,
  input  logic     nvdla_core_rstn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != cnt_w'(depth));   // low when full
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];                 // fall-through head
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

//--- src/sdp_rdma_engine.sv
`timescale 1ns/10ps
`include "sdp_rdma_cfg.svh"

module sdp_rdma_engine
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
(
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        op_en,
  input  rdma_cfg_t   cfg,
  output logic        done,
  output logic        rd_req_valid,
  input  logic        rd_req_ready,
  output dma_rd_req_t rd_req,
  input  logic        rd_rsp_valid,
  output logic        rd_rsp_ready,
  input  dma_rd_rsp_t rd_rsp,
  output logic        dp_valid,
  input  logic        dp_ready,
  output dp_data_t    dp_data
);

  localparam int credit_w = $clog2(`SDP_RDMA_RET_DEPTH + 1);

  typedef enum logic {st_idle, st_busy} state_t;

  state_t                      state;
  logic                        armed;
  logic                        start;
  logic [`SDP_RDMA_ADDR_W-1:0] next_addr;
  logic [`SDP_RDMA_CNT_W-1:0]  req_left;
  logic [`SDP_RDMA_CNT_W-1:0]  rsp_left;
  logic [credit_w-1:0]         credit;   // words between request and datapath
  logic                        req_push;
  logic                        req_push_ready;
  dma_rd_req_t                 req_in;
  dp_data_t                    ret_in;
  logic                        rsp_hs;
  logic                        dp_hs;

  // ==========================================================================
  // request side
  // ==========================================================================
  assign start    = (state == st_idle) & op_en & armed;
  assign req_push = (state == st_busy) & (req_left != '0) &
                    (credit < credit_w'(`SDP_RDMA_RET_DEPTH)) & req_push_ready;
  assign req_in.addr = next_addr;

  // ==========================================================================
  // return side
  // ==========================================================================
  assign rsp_hs      = rd_rsp_valid & rd_rsp_ready;
  assign ret_in.data = rd_rsp.data;
  assign ret_in.last = (rsp_left == `SDP_RDMA_CNT_W'(1));  // responses arrive in order
  assign dp_hs       = dp_valid & dp_ready;
  assign done        = dp_hs & dp_data.last;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state     <= st_idle;
      armed     <= 1'b0;
      next_addr <= '0;
      req_left  <= '0;
      rsp_left  <= '0;
      credit    <= '0;
    end else begin
      if (!op_en) begin
        armed <= 1'b1;  // wait for enable to drop between runs
      end else if (start) begin
        armed <= 1'b0;
      end
      if (start) begin
        state     <= st_busy;
        next_addr <= cfg.base;
        req_left  <= cfg.count;
        rsp_left  <= cfg.count;
      end else begin
        if (done) begin
          state <= st_idle;
        end
        if (req_push) begin
          next_addr <= next_addr + cfg.stride;
          req_left  <= req_left - 1'b1;
        end
        if (rsp_hs) begin
          rsp_left <= rsp_left - 1'b1;
        end
      end
      credit <= credit + credit_w'(req_push) - credit_w'(dp_hs);
    end
  end

  sdp_rdma_fifo #(.payload_t(dma_rd_req_t), .depth(`SDP_RDMA_REQ_DEPTH)) u_req_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (req_push),
    .in_ready        (req_push_ready),
    .in_data         (req_in),
    .out_valid       (rd_req_valid),
    .out_ready       (rd_req_ready),
    .out_data        (rd_req)
  );

  // credit cap keeps this from ever filling while a response waits
  sdp_rdma_fifo #(.payload_t(dp_data_t), .depth(`SDP_RDMA_RET_DEPTH)) u_ret_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (rd_rsp_valid),
    .in_ready        (rd_rsp_ready),
    .in_data         (ret_in),
    .out_valid       (dp_valid),
    .out_ready       (dp_ready),
    .out_data        (dp_data)
  );

endmodule

//--- src/sdp_rdma_reg.sv
`timescale 1ns/10ps
`include "sdp_rdma_cfg.svh"

module sdp_rdma_reg
  import sdp_rdma_reg_pkg::*;
(
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  logic      csb_req_valid,
  output logic      csb_req_ready,
  input  csb_req_t  csb_req,
  output logic      csb_resp_valid,
  output csb_resp_t csb_resp,
  output rdma_cfg_t src_cfg,
  output rdma_cfg_t bs_cfg,
  output logic      mrdma_op_en,
  output logic      brdma_op_en,
  input  logic      mrdma_done,
  input  logic      brdma_done
);

  logic        op_en;
  logic        flying_mode;    // source comes from the core, no fetch
  logic        bs_disable;
  logic        mrdma_pending;
  logic        brdma_pending;
  logic        mrdma_disable;
  logic        brdma_disable;
  logic        op_done;
  logic        wr_en;
  logic [31:0] rd_data;

  assign csb_req_ready = 1'b1;  // every request is taken at once
  assign wr_en         = csb_req_valid & csb_req.write;

  // ==========================================================================
  // engine enables and completion
  // ==========================================================================
  assign mrdma_disable = flying_mode;
  assign brdma_disable = bs_disable;
  assign mrdma_op_en   = op_en & ~mrdma_pending & ~mrdma_disable;
  assign brdma_op_en   = op_en & ~brdma_pending & ~brdma_disable;
  assign op_done       = op_en & (mrdma_pending | mrdma_done | mrdma_disable) &
                         (brdma_pending | brdma_done | brdma_disable);

  always_comb begin
    case (csb_req.addr)
      `SDP_RDMA_REG_OP_EN:      rd_data = {31'd0, op_en};
      `SDP_RDMA_REG_MODE:       rd_data = {30'd0, bs_disable, flying_mode};
      `SDP_RDMA_REG_SRC_BASE:   rd_data = src_cfg.base;
      `SDP_RDMA_REG_SRC_STRIDE: rd_data = src_cfg.stride;
      `SDP_RDMA_REG_SRC_COUNT:  rd_data = 32'(src_cfg.count);
      `SDP_RDMA_REG_BS_BASE:    rd_data = bs_cfg.base;
      `SDP_RDMA_REG_BS_STRIDE:  rd_data = bs_cfg.stride;
      `SDP_RDMA_REG_BS_COUNT:   rd_data = 32'(bs_cfg.count);
      default:                  rd_data = '0;
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en          <= 1'b0;
      flying_mode    <= 1'b0;
      bs_disable     <= 1'b0;
      mrdma_pending  <= 1'b0;
      brdma_pending  <= 1'b0;
      src_cfg        <= '0;
      bs_cfg         <= '0;
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= csb_req_valid;
      if (op_done) begin
        op_en <= 1'b0;
      end else if (wr_en && csb_req.addr == `SDP_RDMA_REG_OP_EN && !op_en) begin
        op_en <= csb_req.wdata[0];  // ignored while running
      end
      if (op_done) begin
        mrdma_pending <= 1'b0;
        brdma_pending <= 1'b0;
      end else begin
        mrdma_pending <= mrdma_pending | mrdma_done;
        brdma_pending <= brdma_pending | brdma_done;
      end
      if (wr_en) begin
        case (csb_req.addr)
          `SDP_RDMA_REG_MODE:       {bs_disable, flying_mode} <= csb_req.wdata[1:0];
          `SDP_RDMA_REG_SRC_BASE:   src_cfg.base   <= csb_req.wdata;
          `SDP_RDMA_REG_SRC_STRIDE: src_cfg.stride <= csb_req.wdata;
          `SDP_RDMA_REG_SRC_COUNT:  src_cfg.count  <= csb_req.wdata[`SDP_RDMA_CNT_W-1:0];
          `SDP_RDMA_REG_BS_BASE:    bs_cfg.base    <= csb_req.wdata;
          `SDP_RDMA_REG_BS_STRIDE:  bs_cfg.stride  <= csb_req.wdata;
          `SDP_RDMA_REG_BS_COUNT:   bs_cfg.count   <= csb_req.wdata[`SDP_RDMA_CNT_W-1:0];
          default:                  ;
        endcase
      end
    end
  end

  // response payload, qualified by csb_resp_valid
  always_ff @(posedge nvdla_core_clk) begin
    csb_resp.wr_ack <= csb_req.write;
    csb_resp.rdata  <= csb_req.write ? 32'd0 : rd_data;
  end

endmodule

//--- src/sdp_rdma.sv
`timescale 1ns/10ps

module sdp_rdma
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
(
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        csb_req_valid,
  output logic        csb_req_ready,
  input  csb_req_t    csb_req,
  output logic        csb_resp_valid,
  output csb_resp_t   csb_resp,
  output logic        src_rd_req_valid,
  input  logic        src_rd_req_ready,
  output dma_rd_req_t src_rd_req,
  input  logic        src_rd_rsp_valid,
  output logic        src_rd_rsp_ready,
  input  dma_rd_rsp_t src_rd_rsp,
  output logic        bs_rd_req_valid,
  input  logic        bs_rd_req_ready,
  output dma_rd_req_t bs_rd_req,
  input  logic        bs_rd_rsp_valid,
  output logic        bs_rd_rsp_ready,
  input  dma_rd_rsp_t bs_rd_rsp,
  output logic        mrdma2cmux_valid,
  input  logic        mrdma2cmux_ready,
  output dp_data_t    mrdma2cmux_pd,
  output logic        brdma2dp_valid,
  input  logic        brdma2dp_ready,
  output dp_data_t    brdma2dp_pd
);

  rdma_cfg_t src_cfg;
  rdma_cfg_t bs_cfg;
  logic      mrdma_op_en;
  logic      brdma_op_en;
  logic      mrdma_done;
  logic      brdma_done;

  // ==========================================================================
  // register block
  // ==========================================================================
  sdp_rdma_reg u_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .csb_req_valid   (csb_req_valid),
    .csb_req_ready   (csb_req_ready),
    .csb_req         (csb_req),
    .csb_resp_valid  (csb_resp_valid),
    .csb_resp        (csb_resp),
    .src_cfg         (src_cfg),
    .bs_cfg          (bs_cfg),
    .mrdma_op_en     (mrdma_op_en),
    .brdma_op_en     (brdma_op_en),
    .mrdma_done      (mrdma_done),
    .brdma_done      (brdma_done)
  );

  // ==========================================================================
  // source feature fetch, toward the channel mux
  // ==========================================================================
  sdp_rdma_engine u_mrdma (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (mrdma_op_en),
    .cfg             (src_cfg),
    .done            (mrdma_done),
    .rd_req_valid    (src_rd_req_valid),
    .rd_req_ready    (src_rd_req_ready),
    .rd_req          (src_rd_req),
    .rd_rsp_valid    (src_rd_rsp_valid),
    .rd_rsp_ready    (src_rd_rsp_ready),
    .rd_rsp          (src_rd_rsp),
    .dp_valid        (mrdma2cmux_valid),
    .dp_ready        (mrdma2cmux_ready),
    .dp_data         (mrdma2cmux_pd)
  );

  // bias operand fetch
  sdp_rdma_engine u_brdma (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (brdma_op_en),
    .cfg             (bs_cfg),
    .done            (brdma_done),
    .rd_req_valid    (bs_rd_req_valid),
    .rd_req_ready    (bs_rd_req_ready),
    .rd_req          (bs_rd_req),
    .rd_rsp_valid    (bs_rd_rsp_valid),
    .rd_rsp_ready    (bs_rd_rsp_ready),
    .rd_rsp          (bs_rd_rsp),
    .dp_valid        (brdma2dp_valid),
    .dp_ready        (brdma2dp_ready),
    .dp_data         (brdma2dp_pd)
  );

endmodule

//--- dv/sdp_rdma_chk.sv
`timescale 1ns/10ps
`include "sdp_rdma_cfg.svh"

module sdp_rdma_chk
  import sdp_rdma_dma_pkg::*;
(
  input logic        nvdla_core_clk,
  input logic        nvdla_core_rstn,
  input logic        csb_req_valid,
  input logic        csb_req_ready,
  input logic        csb_resp_valid,
  input logic        src_rd_req_valid,
  input logic        src_rd_req_ready,
  input dma_rd_req_t src_rd_req,
  input logic        bs_rd_req_valid,
  input logic        bs_rd_req_ready,
  input dma_rd_req_t bs_rd_req,
  input logic        mrdma2cmux_valid,
  input logic        mrdma2cmux_ready,
  input dp_data_t    mrdma2cmux_pd,
  input logic        brdma2dp_valid,
  input logic        brdma2dp_ready,
  input dp_data_t    brdma2dp_pd
);

  int err_cnt = 0;  // failed assertions so far
  int src_fly;      // memory requests not yet on the datapath
  int bs_fly;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      src_fly <= 0;
      bs_fly  <= 0;
    end else begin
      src_fly <= src_fly + int'(src_rd_req_valid & src_rd_req_ready)
                         - int'(mrdma2cmux_valid & mrdma2cmux_ready);
      bs_fly  <= bs_fly + int'(bs_rd_req_valid & bs_rd_req_ready)
                        - int'(brdma2dp_valid & brdma2dp_ready);
    end
  end

  // ==========================================================================
  // valid and payload hold until ready
  // ==========================================================================
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    src_rd_req_valid && !src_rd_req_ready |=> src_rd_req_valid && $stable(src_rd_req))
    else begin err_cnt++; $error("source request dropped before ready"); end
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    bs_rd_req_valid && !bs_rd_req_ready |=> bs_rd_req_valid && $stable(bs_rd_req))
    else begin err_cnt++; $error("bias request dropped before ready"); end
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    mrdma2cmux_valid && !mrdma2cmux_ready |=> mrdma2cmux_valid && $stable(mrdma2cmux_pd))
    else begin err_cnt++; $error("source word dropped before ready"); end
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    brdma2dp_valid && !brdma2dp_ready |=> brdma2dp_valid && $stable(brdma2dp_pd))
    else begin err_cnt++; $error("bias word dropped before ready"); end

  // ==========================================================================
  // control response one cycle after each request
  // ==========================================================================
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_req_valid && csb_req_ready |=> csb_resp_valid)
    else begin err_cnt++; $error("control response missing"); end
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> $past(csb_req_valid && csb_req_ready))
    else begin err_cnt++; $error("control response without a request"); end

  // in-flight words bounded by the return FIFO
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    src_fly <= `SDP_RDMA_RET_DEPTH && bs_fly <= `SDP_RDMA_RET_DEPTH)
    else begin err_cnt++; $error("too many words in flight"); end

endmodule

bind sdp_rdma sdp_rdma_chk u_chk (.*);

//--- dv/tb_sdp_rdma.sv
`timescale 1ns/10ps
`include "sdp_rdma_cfg.svh"

// in-order read memory returning {addr, ~addr}
module read_mem_model
  import sdp_rdma_dma_pkg::*;
(
  input  logic        nvdla_core_clk,
  input  logic [7:0]  rnd,
  input  logic        req_valid,
  output logic        req_ready,
  input  dma_rd_req_t req,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output dma_rd_rsp_t rsp
);

  logic [31:0] pend_q [$];  // accepted and not yet returned
  int          rsp_cnt = 0;
  int          seen_cnt;
  logic [2:0]  delay;

  always @(posedge nvdla_core_clk) begin
    if (req_valid && req_ready) begin
      pend_q.push_back(req.addr);
    end
    if (rsp_valid && rsp_ready) begin
      void'(pend_q.pop_front());
      rsp_cnt++;
    end
  end

  initial begin
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp       = '0;
    seen_cnt  = 0;
    delay     = '0;
    forever begin
      @(negedge nvdla_core_clk);
      req_ready = rnd[0] | rnd[1];
      if (rsp_valid && rsp_cnt != seen_cnt) begin
        rsp_valid = 1'b0;  // taken on the last edge
        seen_cnt  = rsp_cnt;
      end
      if (!rsp_valid) begin
        if (delay != 3'd0) begin
          delay = delay - 3'd1;
        end else if (pend_q.size() != 0) begin
          rsp_valid = 1'b1;
          rsp.data  = {pend_q[0], ~pend_q[0]};
          delay     = rnd[4:2];  // gap before the next return
        end
      end
    end
  end

endmodule

module tb_sdp_rdma
  import sdp_rdma_reg_pkg::*;
  import sdp_rdma_dma_pkg::*;
;

  localparam int max_cycles = 20000;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        csb_req_valid;
  logic        csb_req_ready;
  csb_req_t    csb_req;
  logic        csb_resp_valid;
  csb_resp_t   csb_resp;
  logic        src_rd_req_valid;
  logic        src_rd_req_ready;
  dma_rd_req_t src_rd_req;
  logic        src_rd_rsp_valid;
  logic        src_rd_rsp_ready;
  dma_rd_rsp_t src_rd_rsp;
  logic        bs_rd_req_valid;
  logic        bs_rd_req_ready;
  dma_rd_req_t bs_rd_req;
  logic        bs_rd_rsp_valid;
  logic        bs_rd_rsp_ready;
  dma_rd_rsp_t bs_rd_rsp;
  logic        mrdma2cmux_valid;
  logic        mrdma2cmux_ready;
  dp_data_t    mrdma2cmux_pd;
  logic        brdma2dp_valid;
  logic        brdma2dp_ready;
  dp_data_t    brdma2dp_pd;

  integer      seed = 32'hc4af;
  logic [31:0] rnd;
  int          cycles = 0;
  int          req_k [2] = '{0, 0};     // request handshakes so far
  int          dp_k [2] = '{0, 0};      // datapath words so far
  int          req_mark [2] = '{0, 0};  // counts at the start of the run
  int          dp_mark [2] = '{0, 0};
  int          exp_cnt [2] = '{0, 0};
  logic [31:0] exp_base [2];
  logic [31:0] exp_stride [2];
  logic [31:0] src_ref_q [$];
  logic [31:0] bs_ref_q [$];

  sdp_rdma i_sdp_rdma (.*);

  read_mem_model u_src_mem (
    .nvdla_core_clk (nvdla_core_clk),
    .rnd            (rnd[7:0]),
    .req_valid      (src_rd_req_valid),
    .req_ready      (src_rd_req_ready),
    .req            (src_rd_req),
    .rsp_valid      (src_rd_rsp_valid),
    .rsp_ready      (src_rd_rsp_ready),
    .rsp            (src_rd_rsp)
  );

  read_mem_model u_bs_mem (
    .nvdla_core_clk (nvdla_core_clk),
    .rnd            (rnd[15:8]),
    .req_valid      (bs_rd_req_valid),
    .req_ready      (bs_rd_req_ready),
    .req            (bs_rd_req),
    .rsp_valid      (bs_rd_rsp_valid),
    .rsp_ready      (bs_rd_rsp_ready),
    .rsp            (bs_rd_rsp)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  // sinks stall on about a quarter of the cycles
  initial begin
    rnd              = '0;
    mrdma2cmux_ready = 1'b0;
    brdma2dp_ready   = 1'b0;
    forever begin
      @(posedge nvdla_core_clk);
      rnd = $random(seed);
      @(negedge nvdla_core_clk);
      mrdma2cmux_ready = rnd[16] | rnd[17];
      brdma2dp_ready   = rnd[18] | rnd[19];
    end
  end

  // ==========================================================================
  // failure reporting and reference model
  // ==========================================================================
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    fail_run($sformatf("mismatch at %0t ns: %s", $time, msg));
  endtask

  function automatic logic [31:0] addr_of(input int e, input int k);
    return exp_base[e] + 32'(k) * exp_stride[e];  // base plus k times stride
  endfunction

  task automatic check_req(input int e, input logic [31:0] addr);
    int k;
    k = req_k[e] - req_mark[e];
    assert (k < exp_cnt[e]) else fail_run($sformatf("engine %0d issued too many requests", e));
    assert (addr == addr_of(e, k))
      else report_mismatch($sformatf("engine %0d request %0d address %h", e, k, addr));
    req_k[e]++;
  endtask

  task automatic check_word(input int e, input dp_data_t pd, input logic [31:0] addr);
    int idx;
    idx = dp_k[e] - dp_mark[e];
    assert (pd.data == {addr, ~addr})
      else report_mismatch($sformatf("engine %0d word %0d data %h", e, idx, pd.data));
    assert (pd.last == (idx == exp_cnt[e] - 1))
      else report_mismatch($sformatf("engine %0d word %0d last flag %b", e, idx, pd.last));
    dp_k[e]++;
  endtask

  always @(posedge nvdla_core_clk) begin
    if (src_rd_req_valid && src_rd_req_ready) begin
      check_req(0, src_rd_req.addr);
      src_ref_q.push_back(src_rd_req.addr);
    end
    if (bs_rd_req_valid && bs_rd_req_ready) begin
      check_req(1, bs_rd_req.addr);
      bs_ref_q.push_back(bs_rd_req.addr);
    end
    if (mrdma2cmux_valid && mrdma2cmux_ready) begin
      assert (src_ref_q.size() != 0) else fail_run("source word arrived with no request");
      check_word(0, mrdma2cmux_pd, src_ref_q.pop_front());
    end
    if (brdma2dp_valid && brdma2dp_ready) begin
      assert (bs_ref_q.size() != 0) else fail_run("bias word arrived with no request");
      check_word(1, brdma2dp_pd, bs_ref_q.pop_front());
    end
    assert (i_sdp_rdma.u_chk.err_cnt == 0) else fail_run("a bound protocol assertion failed");
    cycles++;
    assert (cycles < max_cycles) else fail_run("the run timed out");
  end

  // ==========================================================================
  // control channel
  // ==========================================================================
  task automatic csb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output csb_resp_t resp);
    @(negedge nvdla_core_clk);
    csb_req_valid = 1'b1;
    csb_req       = {wr, addr, wdata};
    @(posedge nvdla_core_clk);
    while (!csb_req_ready) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    csb_req_valid = 1'b0;
    while (!csb_resp_valid) @(negedge nvdla_core_clk);
    resp = csb_resp;
  endtask

  task automatic csb_write(input logic [7:0] addr, input logic [31:0] wdata);
    csb_resp_t resp;
    csb_xfer(1'b1, addr, wdata, resp);
    assert (resp.wr_ack && resp.rdata == 32'd0)
      else report_mismatch($sformatf("write to %h answered %b/%h", addr, resp.wr_ack, resp.rdata));
  endtask

  task automatic csb_read(input logic [7:0] addr, output logic [31:0] rdata);
    csb_resp_t resp;
    csb_xfer(1'b0, addr, 32'd0, resp);
    assert (!resp.wr_ack) else report_mismatch($sformatf("read of %h carries write ack", addr));
    rdata = resp.rdata;
  endtask

  task automatic reg_check(input logic [7:0] addr, input logic [31:0] val);
    logic [31:0] rd;
    csb_write(addr, val);
    csb_read(addr, rd);
    assert (rd == val)
      else report_mismatch($sformatf("register %h reads %h, wrote %h", addr, rd, val));
  endtask

  // program both engines, start, and poll until the operation ends
  task automatic run_op(input logic [1:0] mode, input logic [31:0] src_base, src_stride,
                        input int src_cnt, input logic [31:0] bs_base, bs_stride,
                        input int bs_cnt);
    logic [31:0] op_val;
    int          e;
    exp_base[0]   = src_base;
    exp_stride[0] = src_stride;
    exp_cnt[0]    = mode[0] ? 0 : src_cnt;  // flying mode fetches no source
    exp_base[1]   = bs_base;
    exp_stride[1] = bs_stride;
    exp_cnt[1]    = mode[1] ? 0 : bs_cnt;
    for (e = 0; e < 2; e++) begin
      req_mark[e] = req_k[e];
      dp_mark[e]  = dp_k[e];
    end
    reg_check(`SDP_RDMA_REG_MODE, {30'd0, mode});
    reg_check(`SDP_RDMA_REG_SRC_BASE, src_base);
    reg_check(`SDP_RDMA_REG_SRC_STRIDE, src_stride);
    reg_check(`SDP_RDMA_REG_SRC_COUNT, 32'(src_cnt));
    reg_check(`SDP_RDMA_REG_BS_BASE, bs_base);
    reg_check(`SDP_RDMA_REG_BS_STRIDE, bs_stride);
    reg_check(`SDP_RDMA_REG_BS_COUNT, 32'(bs_cnt));
    csb_write(`SDP_RDMA_REG_OP_EN, 32'd1);
    op_val = 32'd1;
    while (op_val[0]) begin
      csb_read(`SDP_RDMA_REG_OP_EN, op_val);
    end
    assert (dp_k[0] - dp_mark[0] == exp_cnt[0] && dp_k[1] - dp_mark[1] == exp_cnt[1])
      else fail_run("operation enable cleared before every word was delivered");
    assert (req_k[0] - req_mark[0] == exp_cnt[0] && req_k[1] - req_mark[1] == exp_cnt[1])
      else fail_run("an engine issued fewer requests than programmed");
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    nvdla_core_rstn = 1'b0;
    csb_req_valid   = 1'b0;
    csb_req         = '0;
    repeat (4) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    run_op(2'b10, 32'h0000_1000, 32'h40, 20, 32'h0008_0000, 32'h8, 12);  // bias disabled
    run_op(2'b01, 32'h0000_2000, 32'h40, 16, 32'h0009_0000, 32'h10, 33);  // flying
    run_op(2'b00, rnd & 32'h0fff_fff8, 32'h20, 64, ~rnd & 32'h0fff_fff8, 32'h18, 40);
    repeat (8) @(posedge nvdla_core_clk);
    if (i_sdp_rdma.u_chk.err_cnt != 0) begin
      $display("a bound protocol assertion failed");
      $display("Test failed");
      $fatal(1, "run stopped");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+include
src/sdp_rdma_reg_pkg.sv
src/sdp_rdma_dma_pkg.sv
src/sdp_rdma_fifo.sv
src/sdp_rdma_engine.sv
src/sdp_rdma_reg.sv
src/sdp_rdma.sv
dv/sdp_rdma_chk.sv
dv/tb_sdp_rdma.sv

//--- Makefile
TOP := tb_sdp_rdma
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
